/* hdl/conv_pkg.sv */
`default_nettype none

package conv_pkg;

  // ==================================================
  // Stream control word
  // ==================================================

  typedef struct packed {
    logic start;  // First beat of a pass
    logic valid;
    logic stop;   // Last beat of a pass
  } ctrl_t;

  typedef enum logic [1:0] {
    CORE_WAIT,
    CORE_NETWORK,  // One setup cycle after a command
    CORE_INPUT,
    CORE_OUTPUT
  } core_state_t;

  // ==================================================
  // Fixed sizes and latencies
  // ==================================================

  localparam int KMAX    = 3;  // Largest kernel side
  localparam int D_CONV  = 2;  // Window multiply and adder stages
  localparam int D_ACCUM = 2;  // Feature memory read then write

endpackage

`default_nettype wire

/* hdl/layer_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module layer_sequencer
  import conv_pkg::*;
#(
  parameter int LWIDTH = 6
) (
  input  wire logic              clk,
  input  wire logic              xrst,
  input  wire logic              cmd_valid,
  input  wire logic [LWIDTH-1:0] img_size,
  input  wire logic [LWIDTH-1:0] conv_size,
  input  wire logic [LWIDTH-1:0] n_chan,
  input  wire ctrl_t             in_ctrl,
  input  wire logic              done_stop,
  output core_state_t            core_state,
  output logic                   first_input,
  output logic                   last_input,
  output logic                   busy,
  output logic [LWIDTH-1:0]      cur_img_size,
  output logic [LWIDTH-1:0]      cur_conv_size
);

  logic [LWIDTH-1:0] n_chan_q;
  logic [LWIDTH-1:0] chan_q;     // Channel pass in progress
  logic              pass_end;

  assign pass_end    = in_ctrl.valid && in_ctrl.stop;
  assign first_input = chan_q == '0;
  assign last_input  = chan_q == n_chan_q - 1'b1;
  assign busy        = core_state != CORE_WAIT;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      core_state    <= CORE_WAIT;
      chan_q        <= '0;
      n_chan_q      <= '0;
      cur_img_size  <= '0;
      cur_conv_size <= '0;
    end else begin
      case (core_state)
        CORE_WAIT: begin
          if (cmd_valid) begin
            cur_img_size  <= img_size;
            cur_conv_size <= conv_size;
            n_chan_q      <= n_chan;
            chan_q        <= '0;
            core_state    <= CORE_NETWORK;
          end
        end
        CORE_NETWORK: core_state <= CORE_INPUT;
        CORE_INPUT: begin
          if (pass_end) begin
            if (last_input)
              core_state <= CORE_OUTPUT;  // Channel count stays on the last one
            else
              chan_q <= chan_q + 1'b1;
          end
        end
        CORE_OUTPUT: begin
          if (done_stop)
            core_state <= CORE_WAIT;
        end
        default: core_state <= CORE_WAIT;
      endcase
    end
  end

  // A command while a layer runs would be dropped by the FSM
  assert property (@(posedge clk) disable iff (!xrst) cmd_valid |-> !busy);

endmodule

`default_nettype wire

/* hdl/conv_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_ctrl
  import conv_pkg::*;
#(
  parameter int LWIDTH = 6,
  parameter int FACCUM = 10
) (
  input  wire logic              clk,
  input  wire logic              xrst,
  input  wire ctrl_t             in_ctrl,
  input  wire core_state_t       core_state,
  input  wire logic [LWIDTH-1:0] cur_img_size,
  input  wire logic [LWIDTH-1:0] cur_conv_size,
  input  wire logic              first_input,
  input  wire logic              last_input,
  output ctrl_t                  win_ctrl,
  output logic                   feat_we,
  output logic                   feat_rst,
  output logic [FACCUM-1:0]      feat_addr,
  output logic [FACCUM-1:0]      feat_addr_d1,
  output logic                   rd_en,
  output ctrl_t                  out_ctrl
);

  localparam int DOUT = D_CONV + D_ACCUM;

  logic [LWIDTH-1:0]   x_q;
  logic [LWIDTH-1:0]   y_q;
  logic [LWIDTH-1:0]   fea_size;
  logic [LWIDTH-1:0]   lim;
  logic [2*LWIDTH-1:0] fea_area;
  logic                x_end;
  logic                y_end;
  logic                in_pix;
  logic                out_pos;
  logic                first_q;
  logic                last_q;
  logic                out_go;    // Last window of the final channel has gone by
  logic                wait_q;    // Output positions are all issued
  logic [D_CONV-1:0]   we_pipe;
  logic [D_CONV-1:0]   rst_pipe;
  logic [FACCUM-1:0]   addr_pipe [0:D_CONV];
  ctrl_t               out_pipe  [0:DOUT-1];

  // ==================================================
  // Position counters
  // ==================================================

  assign in_pix   = core_state == CORE_INPUT && in_ctrl.valid;
  assign out_pos  = core_state == CORE_OUTPUT && out_go && !wait_q;
  assign lim      = (core_state == CORE_OUTPUT) ? fea_size : cur_img_size;
  assign x_end    = x_q == lim - 1'b1;
  assign y_end    = y_q == lim - 1'b1;
  assign fea_area = fea_size * fea_size;

  always_ff @(posedge clk) begin
    if (!xrst)
      fea_size <= '0;
    else if (core_state == CORE_NETWORK)
      fea_size <= cur_img_size - cur_conv_size + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      x_q <= '0;
      y_q <= '0;
    end else if (core_state == CORE_NETWORK) begin
      x_q <= '0;
      y_q <= '0;
    end else if (in_pix || out_pos) begin
      if (x_end) begin
        x_q <= '0;
        y_q <= y_end ? '0 : y_q + 1'b1;
      end else begin
        x_q <= x_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      first_q <= 1'b0;
      last_q  <= 1'b0;
      out_go  <= 1'b0;
      wait_q  <= 1'b0;
    end else begin
      first_q <= first_input;  // Lines up with the window controls
      last_q  <= last_input;
      if (core_state == CORE_NETWORK) begin
        out_go <= 1'b0;
        wait_q <= 1'b0;
      end else begin
        if (win_ctrl.stop && last_q)
          out_go <= 1'b1;
        if (out_pos && x_end && y_end)
          wait_q <= 1'b1;
      end
    end
  end

  // ==================================================
  // Window and feature memory control
  // ==================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      win_ctrl <= '0;
    end else begin
      win_ctrl.start <= in_pix && x_q == cur_conv_size - 1'b1
                               && y_q == cur_conv_size - 1'b1;
      win_ctrl.valid <= in_pix && x_q >= cur_conv_size - 1'b1
                               && y_q >= cur_conv_size - 1'b1;
      win_ctrl.stop  <= in_pix && x_end && y_end;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      we_pipe  <= '0;
      rst_pipe <= '0;
    end else begin
      we_pipe  <= {we_pipe[D_CONV-2:0], win_ctrl.valid};
      rst_pipe <= {rst_pipe[D_CONV-2:0], win_ctrl.valid && first_q};  // Overwrite on channel 0
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i <= D_CONV; i++)
        addr_pipe[i] <= '0;
    end else begin
      if (win_ctrl.stop || wait_q)
        addr_pipe[0] <= '0;
      else if (win_ctrl.valid || out_pipe[0].valid)
        addr_pipe[0] <= addr_pipe[0] + 1'b1;
      for (int i = 1; i <= D_CONV; i++)
        addr_pipe[i] <= addr_pipe[i-1];
    end
  end

  assign feat_we      = we_pipe[D_CONV-1];
  assign feat_rst     = rst_pipe[D_CONV-1];
  assign feat_addr    = addr_pipe[D_CONV-1];
  assign feat_addr_d1 = addr_pipe[D_CONV];

  // ==================================================
  // Output control
  // ==================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < DOUT; i++)
        out_pipe[i] <= '0;
    end else begin
      out_pipe[0].start <= out_pos && x_q == '0 && y_q == '0;
      out_pipe[0].valid <= out_pos;
      out_pipe[0].stop  <= out_pos && x_end && y_end;
      for (int i = 1; i < DOUT; i++)
        out_pipe[i] <= out_pipe[i-1];
    end
  end

  assign rd_en    = out_pipe[DOUT-2].valid;  // Loads the read word one cycle ahead of the beat
  assign out_ctrl = out_pipe[DOUT-1];

  // Reads and writes both stay inside the current feature map
  assert property (@(posedge clk) disable iff (!xrst)
    (we_pipe[D_CONV-2] || out_pipe[D_CONV-1].valid) |-> feat_addr < fea_area);

endmodule

`default_nettype wire

/* hdl/conv_window.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_window
  import conv_pkg::*;
#(
  parameter int LWIDTH = 6,
  parameter int DWIDTH = 8,
  parameter int SWIDTH = 24
) (
  input  wire logic                                  clk,
  input  wire logic                                  xrst,
  input  wire ctrl_t                                 in_ctrl,
  input  wire logic signed [DWIDTH-1:0]              in_pixel,
  input  wire logic [KMAX-1:0][KMAX-1:0][DWIDTH-1:0] weights,
  input  wire logic [LWIDTH-1:0]                     cur_img_size,
  input  wire logic [LWIDTH-1:0]                     cur_conv_size,
  input  wire ctrl_t                                 win_ctrl,
  output logic signed [SWIDTH-1:0]                   win_sum
);

  localparam int LDEPTH = 2**LWIDTH;

  logic signed [DWIDTH-1:0]   lines [0:KMAX-2][0:LDEPTH-1];  // Entry 0 is the previous row
  logic signed [DWIDTH-1:0]   win   [0:KMAX-1][0:KMAX-1];
  logic signed [DWIDTH-1:0]   wk    [0:KMAX-1][0:KMAX-1];
  logic signed [2*DWIDTH-1:0] prod  [0:KMAX-1][0:KMAX-1];
  logic signed [SWIDTH-1:0]   sum_c;
  logic [LWIDTH-1:0]          col_q;
  logic [LWIDTH-1:0]          col;
  logic                       prod_v;

  // ==================================================
  // Line buffers and window
  // ==================================================

  assign col = in_ctrl.start ? '0 : col_q;

  always_ff @(posedge clk) begin
    if (!xrst)
      col_q <= '0;
    else if (in_ctrl.valid)
      col_q <= (col == cur_img_size - 1'b1) ? '0 : col + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (in_ctrl.valid) begin
      lines[0][col] <= in_pixel;
      for (int i = 1; i < KMAX-1; i++)
        lines[i][col] <= lines[i-1][col];
      for (int r = 0; r < KMAX; r++)
        for (int c = 0; c < KMAX-1; c++)
          win[r][c] <= win[r][c+1];
      // Newest column enters on the right, oldest row on top
      for (int r = 0; r < KMAX-1; r++)
        win[r][KMAX-1] <= lines[KMAX-2-r][col];
      win[KMAX-1][KMAX-1] <= in_pixel;
    end
  end

  // ==================================================
  // Weights
  // ==================================================

  always_ff @(posedge clk) begin
    if (in_ctrl.start && in_ctrl.valid) begin
      if (cur_conv_size == KMAX) begin
        for (int r = 0; r < KMAX; r++)
          for (int c = 0; c < KMAX; c++)
            wk[r][c] <= weights[r][c];
      end else begin
        // A 2x2 kernel sits in the lower right corner of the window
        for (int i = 0; i < KMAX; i++) begin
          wk[0][i] <= '0;
          wk[i][0] <= '0;
        end
        for (int r = 1; r < KMAX; r++)
          for (int c = 1; c < KMAX; c++)
            wk[r][c] <= weights[r-1][c-1];
      end
    end
  end

  // ==================================================
  // Multiply-accumulate
  // ==================================================

  always_ff @(posedge clk) begin
    if (win_ctrl.valid) begin
      for (int r = 0; r < KMAX; r++)
        for (int c = 0; c < KMAX; c++)
          prod[r][c] <= wk[r][c] * win[r][c];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      prod_v <= 1'b0;
    else
      prod_v <= win_ctrl.valid;
  end

  always_comb begin
    sum_c = '0;
    for (int r = 0; r < KMAX; r++)
      for (int c = 0; c < KMAX; c++)
        sum_c = sum_c + prod[r][c];
  end

  always_ff @(posedge clk) begin
    if (prod_v)
      win_sum <= sum_c;
  end

endmodule

`default_nettype wire

/* hdl/feat_accum.sv */
`timescale 1ns/10ps
`default_nettype none

module feat_accum #(
  parameter int FACCUM = 10,
  parameter int SWIDTH = 24
) (
  input  wire logic              clk,
  input  wire logic              xrst,
  input  wire logic              feat_we,
  input  wire logic              feat_rst,
  input  wire logic [FACCUM-1:0] feat_addr,
  input  wire logic [FACCUM-1:0] feat_addr_d1,
  input  wire logic              rd_en,
  input  wire logic [SWIDTH-1:0] win_sum,
  output logic [SWIDTH-1:0]      out_data
);

  logic [SWIDTH-1:0] mem [0:2**FACCUM-1];
  logic [SWIDTH-1:0] rd_q;
  logic [SWIDTH-1:0] wr_data;

  // The first channel overwrites, later channels add onto the stored sum
  assign wr_data = feat_rst ? win_sum : rd_q + win_sum;

  always_ff @(posedge clk) begin
    rd_q <= mem[feat_addr];
    if (feat_we)
      mem[feat_addr_d1] <= wr_data;  // Same address that was read a cycle earlier
  end

  // ==================================================
  // Read-out
  // ==================================================

  always_ff @(posedge clk) begin
    if (!xrst)
      out_data <= '0;
    else if (rd_en)
      out_data <= rd_q;
  end

endmodule

`default_nettype wire

/* hdl/conv_layer_top.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_layer_top
  import conv_pkg::*;
#(
  parameter int LWIDTH = 6,
  parameter int DWIDTH = 8,
  parameter int FACCUM = 10,
  parameter int SWIDTH = 24
) (
  input  wire logic                                clk,
  input  wire logic                                xrst,
  input  wire logic                                cmd_valid,
  input  wire logic [LWIDTH-1:0]                   img_size,
  input  wire logic [LWIDTH-1:0]                   conv_size,
  input  wire logic [LWIDTH-1:0]                   n_chan,
  input  wire ctrl_t                               in_ctrl,
  input  wire logic signed [DWIDTH-1:0]            in_pixel,
  input  wire logic [KMAX-1:0][KMAX-1:0][DWIDTH-1:0] weights,
  output ctrl_t                                    out_ctrl,
  output logic [SWIDTH-1:0]                        out_data,
  output logic                                     busy
);

  core_state_t              core_state;
  logic                     first_input;
  logic                     last_input;
  logic [LWIDTH-1:0]        cur_img_size;
  logic [LWIDTH-1:0]        cur_conv_size;
  ctrl_t                    win_ctrl;
  logic                     feat_we;
  logic                     feat_rst;
  logic [FACCUM-1:0]        feat_addr;
  logic [FACCUM-1:0]        feat_addr_d1;
  logic                     rd_en;
  logic signed [SWIDTH-1:0] win_sum;

  layer_sequencer #(
    .LWIDTH (LWIDTH)
  ) u_sequencer (
    .clk           (clk),
    .xrst          (xrst),
    .cmd_valid     (cmd_valid),
    .img_size      (img_size),
    .conv_size     (conv_size),
    .n_chan        (n_chan),
    .in_ctrl       (in_ctrl),
    .done_stop     (out_ctrl.stop),
    .core_state    (core_state),
    .first_input   (first_input),
    .last_input    (last_input),
    .busy          (busy),
    .cur_img_size  (cur_img_size),
    .cur_conv_size (cur_conv_size)
  );

  conv_ctrl #(
    .LWIDTH (LWIDTH),
    .FACCUM (FACCUM)
  ) u_ctrl (
    .clk           (clk),
    .xrst          (xrst),
    .in_ctrl       (in_ctrl),
    .core_state    (core_state),
    .cur_img_size  (cur_img_size),
    .cur_conv_size (cur_conv_size),
    .first_input   (first_input),
    .last_input    (last_input),
    .win_ctrl      (win_ctrl),
    .feat_we       (feat_we),
    .feat_rst      (feat_rst),
    .feat_addr     (feat_addr),
    .feat_addr_d1  (feat_addr_d1),
    .rd_en         (rd_en),
    .out_ctrl      (out_ctrl)
  );

  conv_window #(
    .LWIDTH (LWIDTH),
    .DWIDTH (DWIDTH),
    .SWIDTH (SWIDTH)
  ) u_window (
    .clk           (clk),
    .xrst          (xrst),
    .in_ctrl       (in_ctrl),
    .in_pixel      (in_pixel),
    .weights       (weights),
    .cur_img_size  (cur_img_size),
    .cur_conv_size (cur_conv_size),
    .win_ctrl      (win_ctrl),
    .win_sum       (win_sum)
  );

  feat_accum #(
    .FACCUM (FACCUM),
    .SWIDTH (SWIDTH)
  ) u_accum (
    .clk          (clk),
    .xrst         (xrst),
    .feat_we      (feat_we),
    .feat_rst     (feat_rst),
    .feat_addr    (feat_addr),
    .feat_addr_d1 (feat_addr_d1),
    .rd_en        (rd_en),
    .win_sum      (win_sum),
    .out_data     (out_data)
  );

endmodule

`default_nettype wire

/* tests/conv_layer_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_layer_tb
  import conv_pkg::*;
();

  localparam int LWIDTH = 6;
  localparam int DWIDTH = 8;
  localparam int FACCUM = 10;
  localparam int SWIDTH = 24;
  localparam int TCLK   = 40;
  localparam int TDRV   = 2;   // Input drive delay after the rising edge
  localparam int MAXC   = 3;
  localparam int MAXI   = 8;
  localparam logic [31:0] SEED = 32'h7a22_6795;

  // Channels times image area plus map area, summed over every layer of the run
  localparam int WORK  = (64 + 36) + (49 + 36) + (3 * 36 + 16) + (2 * 36 + 16)
                       + (25 + 16) + (2 * 64 + 36);
  localparam int LIMIT = 4 * WORK + 200;

  localparam logic signed [DWIDTH-1:0] DMIN = {1'b1, {(DWIDTH-1){1'b0}}};
  localparam logic signed [DWIDTH-1:0] DMAX = {1'b0, {(DWIDTH-1){1'b1}}};

  logic                                  clk;
  logic                                  xrst;
  logic                                  cmd_valid;
  logic [LWIDTH-1:0]                     img_size;
  logic [LWIDTH-1:0]                     conv_size;
  logic [LWIDTH-1:0]                     n_chan;
  ctrl_t                                 in_ctrl;
  logic signed [DWIDTH-1:0]              in_pixel;
  logic [KMAX-1:0][KMAX-1:0][DWIDTH-1:0] weights;
  ctrl_t                                 out_ctrl;
  logic [SWIDTH-1:0]                     out_data;
  logic                                  busy;

  logic signed [DWIDTH-1:0] pix [0:MAXC-1][0:MAXI-1][0:MAXI-1];
  logic signed [DWIDTH-1:0] wgt [0:MAXC-1][0:KMAX-1][0:KMAX-1];
  logic [SWIDTH-1:0]        exp_q [$];
  string                    test_name;
  int                       n_exp;
  int                       beat_cnt;
  int                       errors;
  int                       checks;
  logic                     stop_seen;

  conv_layer_top #(
    .LWIDTH (LWIDTH),
    .DWIDTH (DWIDTH),
    .FACCUM (FACCUM),
    .SWIDTH (SWIDTH)
  ) dut0 (
    .clk       (clk),
    .xrst      (xrst),
    .cmd_valid (cmd_valid),
    .img_size  (img_size),
    .conv_size (conv_size),
    .n_chan    (n_chan),
    .in_ctrl   (in_ctrl),
    .in_pixel  (in_pixel),
    .weights   (weights),
    .out_ctrl  (out_ctrl),
    .out_data  (out_data),
    .busy      (busy)
  );

  always #(TCLK / 2) clk = ~clk;

  // ==================================================
  // Reference model and checking
  // ==================================================

  function automatic logic [SWIDTH-1:0] ref_feature(input int fy, input int fx,
                                                    input int k, input int nch);
    int acc;
    acc = 0;
    for (int c = 0; c < nch; c++)
      for (int i = 0; i < k; i++)
        for (int j = 0; j < k; j++)
          acc = acc + int'(wgt[c][i][j]) * int'(pix[c][fy+i][fx+j]);
    return acc[SWIDTH-1:0];  // Wraps like the partial sum memory
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // Output beats are stable at the falling edge
  always @(negedge clk) begin
    if (stop_seen) begin
      check_value({test_name, " busy"}, 32'd0, 32'(busy));  // Low one cycle after stop
      stop_seen = 1'b0;
    end
    if (xrst && out_ctrl.valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Output beat %0d of %s arrived with no value expected", beat_cnt, test_name);
      end else begin
        check_value($sformatf("%s beat %0d", test_name, beat_cnt),
                    32'(exp_q.pop_front()), 32'(out_data));
      end
      check_value({test_name, " start"}, 32'(beat_cnt == 0), 32'(out_ctrl.start));
      check_value({test_name, " stop"}, 32'(beat_cnt == n_exp - 1), 32'(out_ctrl.stop));
      if (out_ctrl.stop) begin
        check_value({test_name, " beats"}, 32'(n_exp), 32'(beat_cnt + 1));
        beat_cnt  = 0;
        stop_seen = 1'b1;
      end else begin
        beat_cnt++;
      end
    end
  end

  // ==================================================
  // Stimulus
  // ==================================================

  task automatic fill_random();
    logic [31:0] rnd;
    for (int c = 0; c < MAXC; c++) begin
      for (int y = 0; y < MAXI; y++)
        for (int x = 0; x < MAXI; x++) begin
          rnd = $urandom();
          pix[c][y][x] = rnd[DWIDTH-1:0];
        end
      for (int i = 0; i < KMAX; i++)
        for (int j = 0; j < KMAX; j++) begin
          rnd = $urandom();
          wgt[c][i][j] = rnd[DWIDTH-1:0];
        end
    end
  endtask

  task automatic fill_extreme();
    for (int c = 0; c < MAXC; c++) begin
      for (int y = 0; y < MAXI; y++)
        for (int x = 0; x < MAXI; x++)
          pix[c][y][x] = DMIN;
      for (int i = 0; i < KMAX; i++)
        for (int j = 0; j < KMAX; j++)
          wgt[c][i][j] = ((c + i + j) % 2 == 1) ? DMAX : DMIN;
    end
  endtask

  task automatic run_layer(input string name, input int img, input int k, input int nch);
    int fea;
    fea       = img - k + 1;
    test_name = name;
    n_exp     = fea * fea;
    for (int fy = 0; fy < fea; fy++)
      for (int fx = 0; fx < fea; fx++)
        exp_q.push_back(ref_feature(fy, fx, k, nch));

    cmd_valid = 1'b1;
    img_size  = LWIDTH'(img);
    conv_size = LWIDTH'(k);
    n_chan    = LWIDTH'(nch);
    @(posedge clk);
    #TDRV;
    cmd_valid = 1'b0;
    repeat (2) @(posedge clk);  // Setup cycle, then the input phase is open
    #TDRV;

    for (int c = 0; c < nch; c++) begin
      for (int r = 0; r < KMAX; r++)
        for (int q = 0; q < KMAX; q++)
          weights[r][q] = wgt[c][r][q];
      for (int y = 0; y < img; y++)
        for (int x = 0; x < img; x++) begin
          in_ctrl.start = x == 0 && y == 0;
          in_ctrl.valid = 1'b1;
          in_ctrl.stop  = x == img - 1 && y == img - 1;
          in_pixel      = pix[c][y][x];
          @(posedge clk);
          #TDRV;
        end
      in_ctrl = '0;
      @(posedge clk);
      #TDRV;
    end

    while (busy) begin
      @(posedge clk);
      #TDRV;
    end
    repeat (2) @(posedge clk);
    #TDRV;
  endtask

  initial begin
    void'($urandom(SEED));
    clk       = 1'b0;
    xrst      = 1'b0;
    cmd_valid = 1'b0;
    img_size  = '0;
    conv_size = '0;
    n_chan    = '0;
    in_ctrl   = '0;
    in_pixel  = '0;
    weights   = '0;
    n_exp     = 0;
    beat_cnt  = 0;
    errors    = 0;
    checks    = 0;
    stop_seen = 1'b0;
    test_name = "reset";
    repeat (2) @(posedge clk);
    #TDRV;
    xrst = 1'b1;
    @(posedge clk);
    #TDRV;

    fill_random();
    run_layer("single_k3", 8, 3, 1);
    fill_random();
    run_layer("kernel2", 7, 2, 1);  // Row and column 2 of the weights stay random
    fill_random();
    run_layer("three_chan", 6, 3, 3);
    fill_random();
    run_layer("back_to_back_a", 6, 3, 2);
    fill_random();
    run_layer("back_to_back_b", 5, 2, 1);
    fill_extreme();
    run_layer("extreme", 8, 3, 2);

    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected output values were never produced", exp_q.size());
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  initial begin
    #(LIMIT * TCLK);
    $display("Timeout after %0d clock cycles in %s", LIMIT, test_name);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* conv_layer.f */
hdl/conv_pkg.sv
hdl/layer_sequencer.sv
hdl/conv_ctrl.sv
hdl/conv_window.sv
hdl/feat_accum.sv
hdl/conv_layer_top.sv
tests/conv_layer_tb.sv

/* Makefile */
SRCS := $(wildcard hdl/*.sv tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vconv_layer_tb: conv_layer.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
	  --top-module conv_layer_tb -f conv_layer.f

run: obj_dir/Vconv_layer_tb
	@out="$$(./obj_dir/Vconv_layer_tb)"; echo "$$out"; \
	  echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
